// File: hdl/battleship_params.svh
`ifndef BATTLESHIP_PARAMS_SVH
`define BATTLESHIP_PARAMS_SVH

// Board geometry in cells and pixels
`define BOARD_SIZE   5            // Cells per side
`define CELL_SIZE    58           // Cell pitch without frame
`define FRAME_WIDTH  4            // Frame thickness
`define CELL_STEP    62           // CELL_SIZE + FRAME_WIDTH
`define LINE_WIDTH   2            // Divider thickness
`define LINE_POS     310          // Divider start column

// 640x480 raster, horizontal in pixels
`define H_ACTIVE     640
`define H_FRONT      16
`define H_SYNC       96
`define H_TOTAL      800

// Vertical in lines
`define V_ACTIVE     480
`define V_FRONT      10
`define V_SYNC       2
`define V_TOTAL      525

`define COLOR_WIDTH  8            // Bits per colour channel
`define NUM_BOARDS   2            // Player and PC

`endif

// File: hdl/vgaPkg.sv
`include "battleship_params.svh"

package vgaPkg;

    // Raster position as seen by the renderer
    typedef struct packed {
        logic [9:0] x;            // Column counter
        logic [9:0] y;            // Line counter
        logic       active;       // Inside the visible area
    } pixelPosT;

    // Both syncs are active low
    typedef struct packed {
        logic hsync;
        logic vsync;
    } syncT;

    typedef struct packed {
        logic [`COLOR_WIDTH-1:0] r;
        logic [`COLOR_WIDTH-1:0] g;
        logic [`COLOR_WIDTH-1:0] b;
    } rgbT;

endpackage

// File: hdl/gamePkg.sv
`include "battleship_params.svh"

package gamePkg;

    typedef enum logic [1:0] {
        WATER = 2'd0,
        SHIP  = 2'd1,
        MISS  = 2'd2,
        HIT   = 2'd3
    } cellStateE;

    typedef enum logic [2:0] {
        MOVE_UP    = 3'd0,
        MOVE_DOWN  = 3'd1,
        MOVE_LEFT  = 3'd2,
        MOVE_RIGHT = 3'd3,
        PLACE      = 3'd4,
        FIRE       = 3'd5,
        CLEAR      = 3'd6
    } opcodeE;

    typedef struct packed {
        opcodeE op;
        logic   board;            // 0 player, 1 PC
    } cmdT;

    typedef struct packed {
        logic [2:0] row;
        logic [2:0] col;
    } cursorT;

    // Write request towards one board
    typedef struct packed {
        opcodeE op;
        cursorT pos;
    } cellWriteT;

    // Cell of (row, col) sits at row*BOARD_SIZE + col
    typedef cellStateE [`BOARD_SIZE*`BOARD_SIZE-1:0] boardT;

endpackage

// File: hdl/vgaTiming.sv
`timescale 1ns/100ps
`include "battleship_params.svh"

module vgaTiming (
    input  logic             clk,
    input  logic             arstN,
    output vgaPkg::pixelPosT pos,
    output vgaPkg::syncT     rawSync
);

    localparam int hSyncStart = `H_ACTIVE + `H_FRONT;     // 656
    localparam int hSyncEnd   = hSyncStart + `H_SYNC;     // 752
    localparam int vSyncStart = `V_ACTIVE + `V_FRONT;     // 490
    localparam int vSyncEnd   = vSyncStart + `V_SYNC;     // 492

    logic [9:0] hCnt;
    logic [9:0] vCnt;
    logic       lineEnd;
    logic       frameEnd;

    assign lineEnd  = (hCnt == 10'(`H_TOTAL - 1));
    assign frameEnd = (vCnt == 10'(`V_TOTAL - 1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hCnt <= '0;
            vCnt <= '0;
        end else if (lineEnd) begin
            hCnt <= '0;                               // Wrap at 800
            if (frameEnd) begin
                vCnt <= '0;                           // Wrap at 525
            end else begin
                vCnt <= vCnt + 10'd1;
            end
        end else begin
            hCnt <= hCnt + 10'd1;
        end
    end

    always_comb begin
        pos.x      = hCnt;
        pos.y      = vCnt;
        pos.active = (hCnt < `H_ACTIVE) && (vCnt < `V_ACTIVE);
    end

    // Negative pulses inside the blanking interval
    always_comb begin
        rawSync.hsync = !((hCnt >= hSyncStart) && (hCnt < hSyncEnd));
        rawSync.vsync = !((vCnt >= vSyncStart) && (vCnt < vSyncEnd));
    end

    hCntInRange: assert property (
        @(posedge clk) disable iff (!arstN)
        hCnt <= 10'(`H_TOTAL - 1)
    ) else $error("Horizontal counter ran past the end of the line");

endmodule

// File: hdl/shotControl.sv
`timescale 1ns/100ps
`include "battleship_params.svh"

module shotControl (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   cmdValid,
    input  gamePkg::cmdT           cmd,
    output gamePkg::cursorT        cursor,
    output gamePkg::cellWriteT     wr,
    output logic [`NUM_BOARDS-1:0] wrEn
);
    import gamePkg::*;

    localparam logic [2:0] lastIdx = 3'(`BOARD_SIZE - 1);

    cursorT cursorNext;
    logic   isWrite;

    // Moves clamp at the grid edge and ignore cmd.board
    always_comb begin
        cursorNext = cursor;
        isWrite    = 1'b0;
        if (cmdValid) begin
            case (cmd.op)
                MOVE_UP: begin
                    if (cursor.row != 3'd0) begin
                        cursorNext.row = cursor.row - 3'd1;
                    end
                end
                MOVE_DOWN: begin
                    if (cursor.row != lastIdx) begin
                        cursorNext.row = cursor.row + 3'd1;
                    end
                end
                MOVE_LEFT: begin
                    if (cursor.col != 3'd0) begin
                        cursorNext.col = cursor.col - 3'd1;
                    end
                end
                MOVE_RIGHT: begin
                    if (cursor.col != lastIdx) begin
                        cursorNext.col = cursor.col + 3'd1;
                    end
                end
                PLACE, FIRE, CLEAR: begin
                    isWrite = 1'b1;                   // Goes to the named board
                end
                default: begin
                    isWrite = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cursor <= '0;
            wrEn   <= '0;
        end else begin
            cursor <= cursorNext;
            wrEn   <= '0;                             // Strobe lasts one cycle
            if (isWrite) begin
                wrEn[cmd.board] <= 1'b1;
            end
        end
    end

    // Write payload, qualified by wrEn
    always_ff @(posedge clk) begin
        if (isWrite) begin
            wr.op  <= cmd.op;
            wr.pos <= cursor;                         // Position before this cycle
        end
    end

    cursorInBoard: assert property (
        @(posedge clk) disable iff (!arstN)
        (cursor.row <= lastIdx) && (cursor.col <= lastIdx)
    ) else $error("Cursor left the board");

    wrEnOneHot: assert property (
        @(posedge clk) disable iff (!arstN)
        $onehot0(wrEn)
    ) else $error("Write strobe raised for more than one board");

endmodule

// File: hdl/boardBank.sv
`timescale 1ns/100ps
`include "battleship_params.svh"

module boardBank (
    input  logic               clk,
    input  logic               arstN,
    input  logic               wrEn,
    input  gamePkg::cellWriteT wr,
    output gamePkg::boardT     cells
);
    import gamePkg::*;

    localparam int numCells = `BOARD_SIZE * `BOARD_SIZE;

    logic [4:0] cellIdx;
    cellStateE  target;

    // Flat index of the addressed cell
    assign cellIdx = 5'(wr.pos.row) * 5'(`BOARD_SIZE) + 5'(wr.pos.col);
    assign target  = cells[cellIdx];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numCells; i++) begin
                cells[i] <= WATER;
            end
        end else if (wrEn) begin
            case (wr.op)
                PLACE: begin
                    if (target == WATER) begin
                        cells[cellIdx] <= SHIP;       // Only on open water
                    end
                end
                FIRE: begin
                    if (target == WATER) begin
                        cells[cellIdx] <= MISS;
                    end else if (target == SHIP) begin
                        cells[cellIdx] <= HIT;
                    end
                    // MISS and HIT stay as they are
                end
                CLEAR: begin
                    for (int i = 0; i < numCells; i++) begin
                        cells[i] <= WATER;
                    end
                end
                default: begin
                    cells <= cells;                   // Moves never reach here
                end
            endcase
        end
    end

endmodule

// File: hdl/videoGen.sv
`timescale 1ns/100ps
`include "battleship_params.svh"

module videoGen (
    input  logic             clk,
    input  logic             arstN,
    input  vgaPkg::pixelPosT pos,
    input  vgaPkg::syncT     rawSync,
    input  gamePkg::cursorT  cursor,
    input  gamePkg::boardT   playerCells,
    input  gamePkg::boardT   pcCells,
    output vgaPkg::syncT     sync,
    output vgaPkg::rgbT      rgb
);
    import vgaPkg::*;
    import gamePkg::*;

    localparam rgbT black       = '{r: 8'h00, g: 8'h00, b: 8'h00};
    localparam rgbT white       = '{r: 8'hFF, g: 8'hFF, b: 8'hFF};
    localparam rgbT cursorBrown = '{r: 8'hA5, g: 8'h2A, b: 8'h2A};

    logic [3:0] colIdx;
    logic [3:0] rowIdx;
    logic [9:0] colPx;
    logic [9:0] rowPx;
    logic [3:0] boardCol;
    logic [5:0] cellIdx;
    logic       inLine;
    logic       inCell;
    logic       inPlayer;
    logic       inPc;
    logic       onCursor;
    rgbT        rgbNext;

    // Palette per board side
    function automatic rgbT cellColor(input cellStateE state, input logic pcSide);
        rgbT c;
        case (state)
            WATER:   c = pcSide ? '{r: 8'h20, g: 8'h20, b: 8'h20} : black;
            SHIP:    c = pcSide ? '{r: 8'h80, g: 8'h00, b: 8'h80} : '{r: 8'hFF, g: 8'h00, b: 8'h00};
            MISS:    c = pcSide ? '{r: 8'hFF, g: 8'hFF, b: 8'h00} : '{r: 8'h00, g: 8'h00, b: 8'hFF};
            HIT:     c = pcSide ? '{r: 8'hFF, g: 8'hA5, b: 8'h00} : '{r: 8'h00, g: 8'hFF, b: 8'h00};
            default: c = white;
        endcase
        return c;
    endfunction

    always_comb begin
        colIdx = 4'(pos.x / `CELL_STEP);              // Cell column on screen
        rowIdx = 4'(pos.y / `CELL_STEP);
        colPx  = 10'(colIdx * `CELL_STEP);            // Left edge of that cell
        rowPx  = 10'(rowIdx * `CELL_STEP);
        inLine = (pos.x >= `LINE_POS) && (pos.x < `LINE_POS + `LINE_WIDTH);
    end

    // Interior test against the frame, then which board owns the cell
    always_comb begin
        inCell   = (pos.x >= colPx + `FRAME_WIDTH) &&
                   (pos.x < colPx + `FRAME_WIDTH + `CELL_SIZE) &&
                   (pos.y >= rowPx + `FRAME_WIDTH) &&
                   (pos.y < rowPx + `FRAME_WIDTH + `CELL_SIZE);
        inPlayer = inCell && (colIdx < `BOARD_SIZE) && (rowIdx < `BOARD_SIZE);
        inPc     = inCell && (colIdx >= `BOARD_SIZE) && (colIdx < 2 * `BOARD_SIZE) &&
                   (rowIdx < `BOARD_SIZE);
        boardCol = inPlayer ? colIdx : colIdx - 4'(`BOARD_SIZE);
        cellIdx  = 6'(rowIdx * `BOARD_SIZE + boardCol);
        onCursor = (rowIdx == {1'b0, cursor.row}) && (colIdx == {1'b0, cursor.col});
    end

    always_comb begin
        if (!pos.active) begin
            rgbNext = black;                          // Blanking
        end else if (inLine) begin
            rgbNext = black;                          // Divider
        end else if (inPlayer) begin
            if (onCursor) begin
                rgbNext = cursorBrown;
            end else begin
                rgbNext = cellColor(playerCells[cellIdx], 1'b0);
            end
        end else if (inPc) begin
            rgbNext = cellColor(pcCells[cellIdx], 1'b1);
        end else begin
            rgbNext = white;                          // Frame gaps and background
        end
    end

    // Colour and sync leave on the same edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sync <= '{hsync: 1'b1, vsync: 1'b1};
            rgb  <= '0;
        end else begin
            sync <= rawSync;
            rgb  <= rgbNext;
        end
    end

endmodule

// File: hdl/battleshipTop.sv
`timescale 1ns/100ps
`include "battleship_params.svh"

module battleshipTop (
    input  logic         clk,
    input  logic         arstN,
    input  logic         cmdValid,
    input  gamePkg::cmdT cmd,
    output vgaPkg::syncT sync,
    output vgaPkg::rgbT  rgb
);
    import vgaPkg::*;
    import gamePkg::*;

    pixelPosT               pos;
    syncT                   rawSync;
    cursorT                 cursor;
    cellWriteT              wr;
    logic [`NUM_BOARDS-1:0] wrEn;
    boardT                  boardCells [`NUM_BOARDS];   // 0 player, 1 PC

    vgaTiming timing (
        .clk     (clk),
        .arstN   (arstN),
        .pos     (pos),
        .rawSync (rawSync)
    );

    shotControl control (
        .clk      (clk),
        .arstN    (arstN),
        .cmdValid (cmdValid),
        .cmd      (cmd),
        .cursor   (cursor),
        .wr       (wr),
        .wrEn     (wrEn)
    );

    for (genvar k = 0; k < `NUM_BOARDS; k++) begin : gBoard
        boardBank bank (
            .clk   (clk),
            .arstN (arstN),
            .wrEn  (wrEn[k]),
            .wr    (wr),
            .cells (boardCells[k])
        );
    end

    videoGen render (
        .clk         (clk),
        .arstN       (arstN),
        .pos         (pos),
        .rawSync     (rawSync),
        .cursor      (cursor),
        .playerCells (boardCells[0]),
        .pcCells     (boardCells[1]),
        .sync        (sync),
        .rgb         (rgb)
    );

endmodule

// File: test/battleshipTb.sv
`timescale 1ns/100ps
`include "battleship_params.svh"

module battleshipTb;
    import vgaPkg::*;
    import gamePkg::*;

    localparam int frameLen = `H_TOTAL * `V_TOTAL;    // Output pixels per frame

    logic clk;
    logic arstN;
    logic cmdValid;
    cmdT  cmd;
    syncT sync;
    rgbT  rgb;

    int cycle;                                        // Edges since reset release
    int checks;

    battleshipTop uut (
        .clk      (clk),
        .arstN    (arstN),
        .cmdValid (cmdValid),
        .cmd      (cmd),
        .sync     (sync),
        .rgb      (rgb)
    );

    always #20 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    // One clock, then settle past the edge
    task automatic tick();
        @(posedge clk);
        #1;
        cycle++;
    endtask

    task automatic checkRgb(input string name, input rgbT expected, input rgbT actual);
        checks++;
        if (actual !== expected) begin
            abortRun($sformatf("mismatch %s: expected %06h, actual %06h",
                               name, expected, actual));
        end
    endtask

    task automatic checkSync(input string name, input syncT expected, input syncT actual);
        checks++;
        if (actual !== expected) begin
            abortRun($sformatf("mismatch %s: expected hsync/vsync %b, actual %b",
                               name, expected, actual));
        end
    endtask

    // Output after edge c shows raster position c-1, state settles two edges after a strobe
    task automatic waitForPixel(input int x, input int y);
        int pixelIdx;
        int base;
        int target;
        int guard;
        pixelIdx = y * `H_TOTAL + x;
        base     = cycle + 3;
        target   = base + ((pixelIdx - (base % frameLen) + frameLen) % frameLen) + 1;
        guard    = 0;
        while (cycle < target) begin
            tick();
            guard++;
            if (guard > frameLen + 16) begin
                abortRun("Timed out waiting for the probed pixel to reach the output");
            end
        end
    endtask

    task automatic decodeOp(input string name, output opcodeE opCode);
        opCode = MOVE_UP;
        case (name)
            "MOVE_UP":    opCode = MOVE_UP;
            "MOVE_DOWN":  opCode = MOVE_DOWN;
            "MOVE_LEFT":  opCode = MOVE_LEFT;
            "MOVE_RIGHT": opCode = MOVE_RIGHT;
            "PLACE":      opCode = PLACE;
            "FIRE":       opCode = FIRE;
            "CLEAR":      opCode = CLEAR;
            default: begin
                abortRun({"Unknown opcode in stimulus file: ", name});
            end
        endcase
    endtask

    task automatic issueCommand(input opcodeE opCode, input logic boardSel, input int count);
        int gap;
        for (int i = 0; i < count; i++) begin
            cmd      = '{op: opCode, board: boardSel};
            cmdValid = 1'b1;
            tick();
            cmdValid = 1'b0;
            gap = $urandom % 4;                       // Idle cycles before the next strobe
            repeat (gap) tick();
        end
    endtask

    initial begin : mainSeq
        int          fd;
        int          n;
        int          x;
        int          y;
        int          board;
        int          count;
        int          hs;
        int          vs;
        logic [23:0] value;
        string       line;
        string       kind;
        string       name;
        opcodeE      opCode;

        clk      = 1'b0;
        arstN    = 1'b0;
        cmdValid = 1'b0;
        cmd      = '{op: MOVE_UP, board: 1'b0};
        cycle    = 0;
        checks   = 0;
        n        = $urandom(32'hfe93);                // Single seed for the run
        fd = $fopen("test/battleship_stimulus.txt", "r");
        if (fd == 0) begin
            abortRun("Could not open the stimulus file");
        end
        repeat (3) @(posedge clk);
        #1;
        checkSync("resetSync", '{hsync: 1'b1, vsync: 1'b1}, sync);
        checkRgb("resetRgb", '0, rgb);
        arstN = 1'b1;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s", kind);
                if (kind == "C") begin
                    n = $sscanf(line, "%s %s %d %d", kind, name, board, count);
                    if (n != 4) begin
                        abortRun({"Malformed command line: ", line});
                    end
                    decodeOp(name, opCode);
                    issueCommand(opCode, board[0], count);
                end else if (kind == "P") begin
                    n = $sscanf(line, "%s %s %d %d %h", kind, name, x, y, value);
                    if (n != 5) begin
                        abortRun({"Malformed pixel probe: ", line});
                    end
                    waitForPixel(x, y);
                    checkRgb(name, value, rgb);
                end else if (kind == "S") begin
                    n = $sscanf(line, "%s %s %d %d %d %d", kind, name, x, y, hs, vs);
                    if (n != 6) begin
                        abortRun({"Malformed sync probe: ", line});
                    end
                    waitForPixel(x, y);
                    checkSync(name, '{hsync: hs[0], vsync: vs[0]}, sync);
                end else begin
                    abortRun({"Unrecognised line in stimulus file: ", line});
                end
            end
        end
        $fclose(fd);
        if (checks == 0) begin
            abortRun("No probe was checked, the stimulus file holds none");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: compile.f
+incdir+hdl
hdl/vgaPkg.sv
hdl/gamePkg.sv
hdl/vgaTiming.sv
hdl/shotControl.sv
hdl/boardBank.sv
hdl/videoGen.sv
hdl/battleshipTop.sv
test/battleshipTb.sv

// File: Bender.yml
package:
  name: battleship

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vgaPkg.sv
      - hdl/gamePkg.sv
      - hdl/vgaTiming.sv
      - hdl/shotControl.sv
      - hdl/boardBank.sv
      - hdl/videoGen.sv
      - hdl/battleshipTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/battleshipTb.sv

// File: test/battleship_stimulus.txt
# C opcode board count        command strobes, board 0 player and 1 PC
# P name x y rrggbb           expected colour at raster position (x, y)
# S name x y hsync vsync      expected sync levels at raster position (x, y)
P gapLeft 2 31 ffffff
P cursorHome 31 31 a52a2a
P pcWater 341 31 202020
S hsyncBefore 655 100 1 1
S hsyncStart 656 100 0 1
S hsyncAfter 752 100 1 1
P hBlank 700 100 000000
P divider 311 200 000000
P belowBoards 100 400 ffffff
S vsyncLine490 10 490 1 0
C MOVE_UP 0 1
C MOVE_LEFT 0 1
C MOVE_RIGHT 0 5
C MOVE_DOWN 1 2
P cursorMoved 279 155 a52a2a
P pcNoCursor 589 155 202020
C PLACE 0 1
C PLACE 1 1
C FIRE 1 2
C MOVE_LEFT 0 1
C FIRE 0 2
C FIRE 1 1
C MOVE_UP 0 1
C PLACE 0 1
C FIRE 0 1
C MOVE_UP 0 1
P playerHit 217 93 00ff00
P playerMissKept 217 155 0000ff
P playerShip 279 155 ff0000
P pcMiss 527 155 ffff00
P pcHitKept 589 155 ffa500
C CLEAR 0 1
P hitCleared 217 93 000000
P shipCleared 279 155 000000
P pcUntouched 589 155 ffa500
